// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_des_search
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= ** PASS **

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '$(PASS_TEXT)' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/tb_des_search.sv
`timescale 1ns/1ns

module tb_des_search;
    import des_search_pkg::*;

    localparam int          n       = 6;
    localparam int          rounds  = 8;
    localparam int          msgs    = 1 << n;
    localparam int          regions = 2;
    localparam logic [63:0] mask_i  = 64'h1040008000000000;
    localparam logic [63:0] mask_o  = 64'h0000000210400080;
    // Walk plus run per region, stepping adds a handshake per message
    localparam int run_cycles  = msgs * (rounds + 3) + msgs * 4 + 50;
    localparam int cycle_limit = 3 * 2 * regions * run_cycles;

    localparam int grp_protocol = 0;
    localparam int grp_bias     = 1;
    localparam int grp_run      = 2;
    localparam int grp_restart  = 3;
    localparam int grp_opcode   = 4;

    logic               clk;
    logic               rst_n;
    logic [31:0]        cmd;
    logic               cmd_valid;
    logic               advance_test_cmd;
    logic [31:0]        region;
    logic               cmd_read;
    logic               test_res_ready;
    logic               done;
    logic [count_w-1:0] counter;
    logic [63:0]        ciphertext;

    logic [31:0]        lfsr;
    logic [15:0]        cur_region;   // Region the DUT holds
    logic [n:0]         step_cnt;     // Results since test-mode entry
    logic [count_w-1:0] prev_count;
    logic [count_w-1:0] walk_count;   // Final count of the last walk
    logic [count_w-1:0] exp_count;
    logic [63:0]        cur_plain;
    logic               ready_q;
    logic               done_q;
    logic               in_run;
    int                 done_rises;
    int                 cycles;
    int                 err_count [5];

    des_search_top #(.n(n)) u_dut (
        .clk (clk), .rst_n (rst_n), .cmd (cmd), .cmd_valid (cmd_valid),
        .advance_test_cmd (advance_test_cmd), .region (region), .cmd_read (cmd_read),
        .test_res_ready (test_res_ready), .done (done), .counter (counter),
        .ciphertext (ciphertext)
    );

    function automatic logic masked_parity(input logic [63:0] plain, input logic [63:0] cipher);
        return ^((plain & mask_i) ^ (cipher & mask_o));
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
    endfunction

    task automatic take_random_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr[31]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic record_failure(input int group, input string msg);
        err_count[group] += 1;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Plaintext of the result on display, region then index then zeros
    assign cur_plain = {cur_region, step_cnt[n-1:0], {(64 - region_w - n){1'b0}}};
    assign exp_count = prev_count + count_w'(masked_parity(cur_plain, ciphertext));

    always @(posedge clk) begin
        ready_q <= test_res_ready;
        done_q  <= done;
        if (!rst_n) begin
            step_cnt   <= '0;
            prev_count <= '0;
            in_run     <= 1'b0;
            done_rises <= 0;
        end else begin
            if (cmd_read && cmd[3:0] == cmd_test_mode) begin
                step_cnt   <= '0;
                prev_count <= '0;
            end else if (test_res_ready && !ready_q) begin
                step_cnt   <= step_cnt + 1'b1;
                prev_count <= counter;
            end
            if (cmd_read && cmd[3:0] == cmd_start) begin
                in_run     <= 1'b1;
                done_rises <= 0;
            end else if (cmd_read && cmd[3:0] == cmd_restart) begin
                in_run <= 1'b0;
            end
            if (done && !done_q) done_rises <= done_rises + 1;
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the DUT did not finish within %0d cycles", cycle_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    // Four-phase command handshake
    assert property (@(posedge clk) !rst_n |=> (!cmd_read && !test_res_ready && !done))
        else record_failure(grp_protocol, "handshake outputs not low after reset");
    assert property (@(posedge clk) disable iff (!rst_n) $rose(cmd_read) |-> cmd_valid)
        else record_failure(grp_protocol, "cmd_read rose without cmd_valid");
    assert property (@(posedge clk) disable iff (!rst_n) (cmd_read && cmd_valid) |=> cmd_read)
        else record_failure(grp_protocol, "cmd_read fell while cmd_valid was high");
    assert property (@(posedge clk) disable iff (!rst_n) $fell(cmd_read) |-> !$past(cmd_valid))
        else record_failure(grp_protocol, "cmd_read fell before cmd_valid fell");

    // Test-mode bias step
    assert property (@(posedge clk) disable iff (!rst_n)
                     $rose(test_res_ready) |-> (counter == exp_count))
        else record_failure(grp_bias, "counter does not match the masked parity step");

    // Run mode
    assert property (@(posedge clk) disable iff (!rst_n)
                     $rose(done) |-> (counter == walk_count && counter <= count_w'(msgs)))
        else record_failure(grp_run, "run count differs from the stepped count");
    assert property (@(posedge clk) disable iff (!rst_n) $rose(done) |-> (done_rises == 0))
        else record_failure(grp_run, "done rose more than once in a run");
    assert property (@(posedge clk) disable iff (!rst_n)
                     $fell(done) |-> ($past(cmd_read) && $past(cmd[3:0]) == cmd_restart))
        else record_failure(grp_run, "done fell without a restart acknowledge");
    assert property (@(posedge clk) disable iff (!rst_n) (in_run || done) |-> !test_res_ready)
        else record_failure(grp_run, "test_res_ready high during a run");

    // Restart
    assert property (@(posedge clk) disable iff (!rst_n)
                     ($fell(cmd_read) && $past(cmd[3:0]) == cmd_restart) |-> !done)
        else record_failure(grp_restart, "done still high after restart");
    assert property (@(posedge clk) disable iff (!rst_n)
                     ($rose(test_res_ready) && step_cnt == '0) |-> (counter <= count_w'(1)))
        else record_failure(grp_restart, "first test step did not start from zero");

    assert property (@(posedge clk) disable iff (!rst_n)
                     (cmd_valid && cmd[3:0] > 4'h3) |=> !cmd_read)
        else record_failure(grp_opcode, "unknown opcode was acknowledged");

    // Tasks start right after a rising edge
    task automatic send_cmd(input logic [3:0] op);
        cmd       <= {28'h0, op};
        cmd_valid <= 1'b1;
        do @(posedge clk); while (!cmd_read);
        cmd_valid <= 1'b0;
        do @(posedge clk); while (cmd_read);
    endtask

    task automatic send_unknown_cmd(input logic [3:0] op);
        cmd       <= {28'h0, op};
        cmd_valid <= 1'b1;
        repeat (8) @(posedge clk);  // Long enough for a missed ack to show
        cmd_valid <= 1'b0;
        @(posedge clk);
    endtask

    task automatic load_region(input logic [31:0] value);
        region     <= value;
        cur_region <= value[15:0];
        send_cmd(cmd_read_region);
    endtask

    task automatic walk_region();
        send_cmd(cmd_test_mode);
        do @(posedge clk); while (!test_res_ready);
        for (int i = 1; i < msgs; i++) begin
            advance_test_cmd <= 1'b1;
            do @(posedge clk); while (test_res_ready);
            advance_test_cmd <= 1'b0;
            do @(posedge clk); while (!test_res_ready);
        end
        walk_count <= counter;
        @(posedge clk);
    endtask

    task automatic run_region();
        send_cmd(cmd_start);
        do @(posedge clk); while (!done);
        repeat (4) @(posedge clk);  // done must hold until restart
        send_cmd(cmd_restart);
    endtask

    initial begin
        logic [31:0] value;
        int          total;

        rst_n            = 1'b0;
        cmd              = '0;
        cmd_valid        = 1'b0;
        advance_test_cmd = 1'b0;
        region           = '0;
        lfsr             = 32'h4a772154;
        cur_region       = '0;
        walk_count       = '0;
        cycles           = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        send_unknown_cmd(4'h9);
        for (int r = 0; r < regions; r++) begin
            take_random_bits(16, value);
            load_region(value);
            walk_region();
            send_cmd(cmd_restart);
            run_region();
        end
        repeat (4) @(posedge clk);

        total = err_count[0] + err_count[1] + err_count[2] + err_count[3] + err_count[4];
        $display("Errors: protocol %0d, bias %0d, run %0d, restart %0d, opcode %0d, total %0d",
                 err_count[grp_protocol], err_count[grp_bias], err_count[grp_run],
                 err_count[grp_restart], err_count[grp_opcode], total);
        if (total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: source/bias_accumulator.sv
`timescale 1ns/1ns

module bias_accumulator #(
    parameter logic [des_search_pkg::block_w-1:0] mask_i = 64'h1040008000000000,
    parameter logic [des_search_pkg::block_w-1:0] mask_o = 64'h0000000210400080
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               clear,
    input  logic                               enable,
    input  logic [des_search_pkg::block_w-1:0] plaintext,
    input  logic [des_search_pkg::block_w-1:0] cipher_out,
    output logic [des_search_pkg::count_w-1:0] match_count
);
    import des_search_pkg::*;

    logic [block_w-1:0] masked;
    logic               parity;

    // Linear approximation holds when this parity is one
    assign masked = (plaintext & mask_i) ^ (cipher_out & mask_o);
    assign parity = ^masked;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            match_count <= '0;
        end else if (clear) begin
            match_count <= '0;
        end else if (enable) begin
            match_count <= match_count + {{(count_w - 1){1'b0}}, parity};
        end
    end

endmodule

// File: source/des_cipher.sv
`timescale 1ns/1ns

module des_cipher #(
    parameter int                   rounds     = 8,
    parameter logic [rounds*48-1:0] round_keys = '0
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               start,
    input  logic [des_search_pkg::block_w-1:0] plaintext,
    output logic [des_search_pkg::block_w-1:0] cipher_out,
    output logic                               cipher_done
);
    import des_search_pkg::*;

    localparam int cnt_w = (rounds > 1) ? $clog2(rounds) : 1;
    localparam int half  = block_w / 2;

    logic [half-1:0]  l_half;
    logic [half-1:0]  r_half;
    logic [half-1:0]  f_out;
    logic [47:0]      round_key;
    logic [cnt_w-1:0] round_cnt;
    logic             busy;
    logic             last_round;

    assign round_key  = round_keys[round_cnt * 48 +: 48];  // First round in the low bits
    assign last_round = busy && (round_cnt == cnt_w'(rounds - 1));

    des_round u_round (
        .r_in      (r_half),
        .round_key (round_key),
        .f_out     (f_out)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            round_cnt   <= '0;
            cipher_done <= 1'b0;
        end else begin
            cipher_done <= last_round;
            if (start) begin
                busy      <= 1'b1;
                round_cnt <= '0;
            end else if (last_round) begin
                busy      <= 1'b0;
                round_cnt <= '0;
            end else if (busy) begin
                round_cnt <= round_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            l_half <= plaintext[block_w-1:half];
            r_half <= plaintext[half-1:0];
        end else if (busy) begin
            l_half <= r_half;
            r_half <= l_half ^ f_out;
        end
        if (last_round) begin
            cipher_out <= {l_half ^ f_out, r_half};  // Halves swapped after the last round
        end
    end

    // One message in flight only
    assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy)
        else $error("cipher started while a block is still in flight");

endmodule

// File: source/des_round.sv
`timescale 1ns/1ns

module des_round (
    input  logic [31:0] r_in,
    input  logic [47:0] round_key,
    output logic [31:0] f_out
);
    import des_search_pkg::*;

    // Tables use DES bit numbers, bit 1 is the MSB
    localparam int e_tab [48] = '{
        32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,
         8,  9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
        16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
        24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1
    };

    localparam int p_tab [32] = '{
        16,  7, 20, 21, 29, 12, 28, 17,
         1, 15, 23, 26,  5, 18, 31, 10,
         2,  8, 24, 14, 32, 27,  3,  9,
        19, 13, 30,  6, 22, 11,  4, 25
    };

    logic [47:0] expanded;
    logic [47:0] mixed;
    logic [31:0] sbox_out;

    // Expansion E, 32 to 48 bits
    always_comb begin
        for (int i = 0; i < 48; i++) begin
            expanded[47 - i] = r_in[32 - e_tab[i]];
        end
    end

    assign mixed = expanded ^ round_key;  // Key mix

    // Eight S-boxes, S1 takes the top six bits
    always_comb begin
        logic [5:0] chunk;
        logic [5:0] idx;

        chunk = '0;
        idx = '0;
        for (int s = 0; s < 8; s++) begin
            chunk = mixed[47 - 6 * s -: 6];
            idx = {chunk[5], chunk[0], chunk[4:1]};  // Outer bits pick the row
            sbox_out[31 - 4 * s -: 4] = sbox_table[s][idx];
        end
    end

    // Permutation P
    always_comb begin
        for (int i = 0; i < 32; i++) begin
            f_out[31 - i] = sbox_out[32 - p_tab[i]];
        end
    end

endmodule

// File: source/des_search_pkg.sv
package des_search_pkg;

    localparam int count_w  = 48;   // Bias counter
    localparam int region_w = 16;
    localparam int block_w  = 64;

    // Low nibble of the command word
    typedef enum logic [3:0] {
        cmd_read_region = 4'h0,
        cmd_start       = 4'h1,
        cmd_test_mode   = 4'h2,
        cmd_restart     = 4'h3
    } cmd_e;

    typedef enum logic [3:0] {
        st_init,
        st_set_region,
        st_start_init,      // Run command acknowledged
        st_start,
        st_waiting,
        st_finishing,       // Result on counter, done high
        st_restart,
        st_test_init,
        st_test_start,
        st_test_mode,
        st_advance_test,
        st_advance_wait
    } ctrl_state_e;

    // DES S1..S8, each row-major as [row * 16 + column]
    localparam logic [0:7][0:63][3:0] sbox_table = {
        256'hE4D12FB83A6C5907_0F74E2D1A6CB9538_41E8D62BFC973A50_FC8249175B3EA06D,
        256'hF18E6B34972DC05A_3D47F28EC01A69B5_0E7BA4D158C6932F_D8A13F42B67C05E9,
        256'hA09E63F51DC7B428_D709346A285ECBF1_D6498F30B12C5AE7_1AD069874FE3B52C,
        256'h7DE3069A1285BC4F_D8B56F03472C1AE9_A690CB7DF13E5284_3F06A1D8945BC72E,
        256'h2C417AB6853FD0E9_EB2C47D150FA3986_421BAD78F9C5630E_B8C71E2D6F09A453,
        256'hC1AF92680D34E75B_AF427C9561DE0B38_9EF528C3704A1DB6_432C95FABE17608D,
        256'h4B2EF08D3C975A61_D0B7491AE35C2F86_14BDC37EAF680592_6BD814A7950FE23C,
        256'hD2846FB1A93E50C7_1FD8A374C56B0E92_7B419CE206ADF358_21E74A8DFC90356B
    };

endpackage

// File: source/des_search_top.sv
`timescale 1ns/1ns

module des_search_top #(
    parameter int                   n          = 24,
    parameter int                   rounds     = 8,
    parameter logic [rounds*48-1:0] round_keys = '0,
    parameter logic [63:0]          mask_i     = 64'h1040008000000000,
    parameter logic [63:0]          mask_o     = 64'h0000000210400080
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [31:0]                        cmd,
    input  logic                               cmd_valid,
    input  logic                               advance_test_cmd,
    input  logic [31:0]                        region,
    output logic                               cmd_read,
    output logic                               test_res_ready,
    output logic                               done,
    output logic [des_search_pkg::count_w-1:0] counter,
    output logic [63:0]                        ciphertext
);
    import des_search_pkg::*;

    logic [region_w-1:0] region_sel;
    logic [n-1:0]        msg_index;
    logic [block_w-1:0]  plaintext;
    logic [block_w-1:0]  cipher_out;
    logic [count_w-1:0]  match_count;
    logic                msg_last;
    logic                msg_clear;
    logic                msg_advance;
    logic                acc_clear;
    logic                acc_enable;
    logic                cipher_start;
    logic                cipher_done;

    // Region, then message index, then zero padding
    assign plaintext = {region_sel, msg_index, {(block_w - region_w - n){1'b0}}};

    search_control #(.n(n)) u_control (
        .clk (clk), .rst_n (rst_n), .cmd (cmd), .cmd_valid (cmd_valid),
        .advance_test_cmd (advance_test_cmd), .region (region),
        .cipher_done (cipher_done), .cipher_out (cipher_out), .msg_last (msg_last),
        .match_count (match_count), .cmd_read (cmd_read), .test_res_ready (test_res_ready),
        .done (done), .counter (counter), .ciphertext (ciphertext),
        .region_sel (region_sel), .cipher_start (cipher_start), .msg_clear (msg_clear),
        .msg_advance (msg_advance), .acc_clear (acc_clear), .acc_enable (acc_enable)
    );

    message_counter #(.n(n)) u_msg_counter (
        .clk (clk), .rst_n (rst_n), .clear (msg_clear), .advance (msg_advance),
        .msg_index (msg_index), .msg_last (msg_last)
    );

    des_cipher #(.rounds(rounds), .round_keys(round_keys)) u_cipher (
        .clk (clk), .rst_n (rst_n), .start (cipher_start), .plaintext (plaintext),
        .cipher_out (cipher_out), .cipher_done (cipher_done)
    );

    bias_accumulator #(.mask_i(mask_i), .mask_o(mask_o)) u_accumulator (
        .clk (clk), .rst_n (rst_n), .clear (acc_clear), .enable (acc_enable),
        .plaintext (plaintext), .cipher_out (cipher_out), .match_count (match_count)
    );

endmodule

// File: source/message_counter.sv
`timescale 1ns/1ns

module message_counter #(
    parameter int n = 24
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         clear,
    input  logic         advance,
    output logic [n-1:0] msg_index,
    output logic         msg_last
);

    // Plaintext index within the region
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            msg_index <= '0;
        end else if (clear) begin
            msg_index <= '0;
        end else if (advance) begin
            msg_index <= msg_index + 1'b1;  // Wraps after the last message
        end
    end

    assign msg_last = &msg_index;

    // Control never steps and clears in the same cycle
    assert property (@(posedge clk) disable iff (!rst_n) !(advance && clear))
        else $error("message counter got advance and clear together");

endmodule

// File: source/search_control.sv
`timescale 1ns/1ns

module search_control #(
    parameter int n = 24
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [31:0]                         cmd,
    input  logic                                cmd_valid,
    input  logic                                advance_test_cmd,
    input  logic [31:0]                         region,
    input  logic                                cipher_done,
    input  logic [des_search_pkg::block_w-1:0]  cipher_out,
    input  logic                                msg_last,
    input  logic [des_search_pkg::count_w-1:0]  match_count,
    output logic                                cmd_read,
    output logic                                test_res_ready,
    output logic                                done,
    output logic [des_search_pkg::count_w-1:0]  counter,
    output logic [des_search_pkg::block_w-1:0]  ciphertext,
    output logic [des_search_pkg::region_w-1:0] region_sel,
    output logic                                cipher_start,
    output logic                                msg_clear,
    output logic                                msg_advance,
    output logic                                acc_clear,
    output logic                                acc_enable
);
    import des_search_pkg::*;

    ctrl_state_e state;
    ctrl_state_e next_state;
    cmd_e        opcode;
    logic        test_active;
    logic        done_d1;      // Accumulator holds the latest result
    logic        res_valid;    // Test result settled on counter
    logic        done_r;
    logic        restart_req;

    assign opcode      = cmd_e'(cmd[3:0]);
    assign restart_req = cmd_valid && (opcode == cmd_restart);

    always_comb begin
        next_state = state;
        case (state)
            st_init: begin
                if (cmd_valid) begin
                    case (opcode)
                        cmd_read_region: next_state = st_set_region;
                        cmd_start:       next_state = st_start_init;
                        cmd_test_mode:   next_state = st_test_init;
                        cmd_restart:     next_state = st_restart;
                        default:         next_state = st_init;  // Unknown code, no ack
                    endcase
                end
            end
            st_set_region, st_restart: begin
                if (!cmd_valid) next_state = st_init;
            end
            st_start_init: begin
                if (!cmd_valid) next_state = st_start;
            end
            st_start: next_state = st_waiting;
            st_waiting: begin
                if (cipher_done && msg_last) begin
                    next_state = st_finishing;
                end else if (done_d1) begin
                    next_state = st_start;
                end
            end
            st_finishing: begin
                if (restart_req) next_state = st_restart;
            end
            st_test_init: begin
                if (!cmd_valid) next_state = st_test_start;
            end
            st_test_start: next_state = st_test_mode;
            st_test_mode: begin
                if (advance_test_cmd && res_valid) begin
                    next_state = st_advance_test;
                end else if (restart_req && res_valid) begin
                    next_state = st_restart;  // Only with the cipher idle
                end
            end
            st_advance_test: next_state = st_advance_wait;
            st_advance_wait: begin
                if (!advance_test_cmd) next_state = st_test_mode;
            end
            default: next_state = st_init;
        endcase
    end

    assign cmd_read = (state == st_set_region) || (state == st_start_init) ||
                      (state == st_test_init) || (state == st_restart);
    assign test_active = (state == st_test_start) || (state == st_test_mode) ||
                         (state == st_advance_test) || (state == st_advance_wait);
    assign cipher_start = (state == st_start) || (state == st_test_start) ||
                          (state == st_advance_test);
    assign msg_clear = (state == st_start_init) || (state == st_test_init) ||
                       (state == st_restart);
    assign acc_clear   = msg_clear;
    assign acc_enable  = cipher_done && ((state == st_waiting) || test_active);
    assign msg_advance = acc_enable && !(msg_last && (state == st_waiting));  // Run stops on last

    assign test_res_ready = (state == st_test_mode) && res_valid;
    assign done           = done_r;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= st_init;
            done_d1   <= 1'b0;
            res_valid <= 1'b0;
            done_r    <= 1'b0;
            counter   <= '0;
        end else begin
            state   <= next_state;
            done_d1 <= cipher_done;
            done_r  <= (state == st_finishing);  // Counter already loaded when done rises
            if (cipher_start || !test_active) begin
                res_valid <= 1'b0;
            end else if (done_d1) begin
                res_valid <= 1'b1;
            end
            if ((state == st_finishing) || test_active) begin
                counter <= match_count;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_set_region) begin
            region_sel <= region[region_w-1:0];
        end
        ciphertext <= cipher_out;  // One cycle behind the cipher
    end

    assert property (@(posedge clk) disable iff (!rst_n) $rose(cmd_read) |-> cmd_valid)
        else $error("cmd_read rose without a pending request");

    assert property (@(posedge clk) disable iff (!rst_n) !(done && test_res_ready))
        else $error("done and test_res_ready high together");

endmodule

// File: vlog.f
source/des_search_pkg.sv
source/des_round.sv
source/des_cipher.sv
source/message_counter.sv
source/bias_accumulator.sv
source/search_control.sv
source/des_search_top.sv
dv/tb_des_search.sv
